/* fir_axil_regs.sv */
// AXI-Lite slave with the ap_ctrl register, tap access gating and read mux
`timescale 1ns/1ps

module fir_axil_regs (
    input  logic                       axis_clk,
    input  logic                       axis_rst_n,
    input  logic                       awvalid,
    input  logic [fir_pkg::ADDR_W-1:0] awaddr,
    input  logic                       wvalid,
    input  fir_pkg::data_t             wdata,
    input  logic                       arvalid,
    input  logic [fir_pkg::ADDR_W-1:0] araddr,
    input  logic                       rready,
    output logic                       awready,
    output logic                       wready,
    output logic                       arready,
    output logic                       rvalid,
    output fir_pkg::data_t             rdata,
    input  logic                       run_done,
    input  logic                       ss_ready,
    input  logic                       sm_valid,
    output logic                       start,
    output logic                       idle,
    output logic                       tap_we,
    output logic [fir_pkg::ADDR_W-1:0] tap_waddr,
    output fir_pkg::data_t             tap_wdata,
    output logic [fir_pkg::ADDR_W-1:0] tap_raddr,
    input  fir_pkg::data_t             tap_rdata
);
    import fir_pkg::*;

    logic [ADDR_W-1:0] waddr_q;
    data_t             wdata_q;
    logic              wr_ack;
    logic [ADDR_W-1:0] raddr_q;
    logic              rd_ack;
    logic              rvalid_q;
    data_t             rdata_q;
    ap_ctrl_u          ap_q;
    ap_ctrl_u          wr_word;
    logic              wr_ctrl;
    logic              start_req;
    logic              rd_ctrl;
    data_t             rd_mux;

    // byte address inside the tap window
    function automatic logic is_tap_addr(input logic [ADDR_W-1:0] addr);
        return (addr >= ADDR_TAP_BASE) && (addr < ADDR_TAP_BASE + ADDR_W'(4 * TAP_NUM));
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // write channel takes address and data together
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge axis_clk) begin
        if (awvalid && wvalid && !wr_ack) begin
            waddr_q <= awaddr;
            wdata_q <= wdata;
        end
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            wr_ack <= 1'b0;
        end else begin
            wr_ack <= awvalid && wvalid && !wr_ack;
        end
    end

    assign wr_word.raw = wdata_q;
    assign wr_ctrl     = wr_ack && (waddr_q == ADDR_AP_CTRL);
    assign start_req   = wr_ctrl && wr_word.fields.start && ap_q.fields.idle;

    // taps are writable only while idle
    assign tap_we    = wr_ack && is_tap_addr(waddr_q) && ap_q.fields.idle;
    assign tap_waddr = waddr_q;
    assign tap_wdata = wdata_q;

    ////////////////////////////////////////////////////////////////////////////
    // read channel
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge axis_clk) begin
        if (arvalid && !rd_ack && !rvalid_q) begin
            raddr_q <= araddr;
        end
        if (rd_ack) begin
            rdata_q <= rd_mux;
        end
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            rd_ack   <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            rd_ack <= arvalid && !rd_ack && !rvalid_q;
            if (rd_ack) begin
                rvalid_q <= 1'b1;
            end else if (rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    assign rd_ctrl   = (raddr_q == ADDR_AP_CTRL);
    assign tap_raddr = raddr_q;

    // busy or unmapped reads see all ones
    always_comb begin
        if (rd_ctrl) begin
            rd_mux = ap_q.raw;
        end else if (is_tap_addr(raddr_q) && ap_q.fields.idle) begin
            rd_mux = tap_rdata;
        end else begin
            rd_mux = TAP_ALL_ONES;
        end
    end

    // ap_ctrl register with a single cycle start pulse
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            ap_q.raw         <= '0;
            ap_q.fields.idle <= 1'b1;
        end else begin
            ap_q.fields.start    <= start_req;
            ap_q.fields.ss_ready <= ss_ready;
            ap_q.fields.sm_valid <= sm_valid;
            if (run_done) begin
                ap_q.fields.idle <= 1'b1;
            end else if (start_req) begin
                ap_q.fields.idle <= 1'b0;
            end
            // done clears once it has been read
            if (run_done) begin
                ap_q.fields.done <= 1'b1;
            end else if (rd_ack && rd_ctrl) begin
                ap_q.fields.done <= 1'b0;
            end
        end
    end

    assign awready = wr_ack;
    assign wready  = wr_ack;
    assign arready = rd_ack;
    assign rvalid  = rvalid_q;
    assign rdata   = rdata_q;
    assign start   = ap_q.fields.start;
    assign idle    = ap_q.fields.idle;

endmodule

/* fir_ctrl_fsm.sv */
// sequencer for sample accept, MAC pass, drain and output hold
`timescale 1ns/1ps

module fir_ctrl_fsm (
    input  logic axis_clk,
    input  logic axis_rst_n,
    input  logic start,
    input  logic ss_tvalid,
    input  logic ss_tlast,
    input  logic sm_tready,
    input  logic cnt_last,
    output logic ss_tready,
    output logic sm_tvalid,
    output logic sm_tlast,
    output logic hist_clear,
    output logic hist_push,
    output logic cnt_clear,
    output logic cnt_step,
    output logic mac_clear,
    output logic mac_en,
    output logic run_done
);
    import fir_pkg::*;

    fir_state_e state;
    fir_state_e state_nxt;
    logic       last_q;
    logic       in_xfer;
    logic       out_xfer;

    assign in_xfer  = ss_tvalid && ss_tready;
    assign out_xfer = sm_tvalid && sm_tready;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (start) begin
                    state_nxt = WAIT_IN;
                end
            end
            WAIT_IN: begin
                if (in_xfer) begin
                    state_nxt = MAC;
                end
            end
            // one cycle per tap
            MAC: begin
                if (cnt_last) begin
                    state_nxt = DRAIN;
                end
            end
            // last product still going into the accumulator
            DRAIN: state_nxt = OUT;
            OUT: begin
                if (out_xfer) begin
                    state_nxt = last_q ? IDLE : WAIT_IN;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state  <= IDLE;
            last_q <= 1'b0;
        end else begin
            state <= state_nxt;
            if (in_xfer) begin
                last_q <= ss_tlast;
            end
        end
    end

    assign ss_tready  = (state == WAIT_IN);
    assign sm_tvalid  = (state == OUT);
    assign sm_tlast   = sm_tvalid && last_q;
    assign hist_clear = (state == IDLE) && start;
    assign hist_push  = in_xfer;
    assign cnt_clear  = in_xfer;
    assign mac_clear  = in_xfer;
    assign cnt_step   = (state == MAC);
    assign mac_en     = (state == MAC);
    assign run_done   = out_xfer && last_q;

endmodule

/* fir_data_ram.sv */
// circular sample history with head pointer, clear and indexed read
`timescale 1ns/1ps

module fir_data_ram (
    input  logic              axis_clk,
    input  logic              axis_rst_n,
    input  logic              hist_clear,
    input  logic              hist_push,
    input  fir_pkg::data_t    ss_tdata,
    input  fir_pkg::tap_idx_t tap_idx,
    output fir_pkg::data_t    hist_sample
);
    import fir_pkg::*;

    data_t    hist_mem [TAP_NUM];
    tap_idx_t head;
    tap_idx_t head_nxt;
    tap_idx_t rd_idx;

    // head points at the newest sample
    assign head_nxt = (head == tap_idx_t'(TAP_NUM - 1)) ? '0 : head + tap_idx_t'(1);

    // head - tap_idx modulo TAP_NUM
    assign rd_idx = (head >= tap_idx) ? head - tap_idx
                                      : head - tap_idx + tap_idx_t'(TAP_NUM);

    assign hist_sample = hist_mem[rd_idx];

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            head <= '0;
        end else if (hist_clear) begin
            head <= '0;
        end else if (hist_push) begin
            head <= head_nxt;
        end
    end

    // old samples read back as zero after a start
    always_ff @(posedge axis_clk) begin
        if (hist_clear) begin
            for (int i = 0; i < TAP_NUM; i++) begin
                hist_mem[i] <= '0;
            end
        end else if (hist_push) begin
            hist_mem[head_nxt] <= ss_tdata;
        end
    end

endmodule

/* fir_mac.sv */
// registered multiply, wrapping accumulator and output data register
`timescale 1ns/1ps

module fir_mac (
    input  logic           axis_clk,
    input  logic           axis_rst_n,
    input  logic           mac_clear,
    input  logic           mac_en,
    input  fir_pkg::data_t tap_coef,
    input  fir_pkg::data_t hist_sample,
    output fir_pkg::data_t sm_tdata
);
    import fir_pkg::*;

    data_t prod_q;
    data_t acc_q;
    logic  prod_vld;

    // product valid trails mac_en by one cycle
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            prod_vld <= 1'b0;
        end else begin
            prod_vld <= mac_en;
        end
    end

    // low 32 bits of the product only
    always_ff @(posedge axis_clk) begin
        if (mac_en) begin
            prod_q <= tap_coef * hist_sample;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (mac_clear) begin
            acc_q <= '0;
        end else if (prod_vld) begin
            acc_q <= acc_q + prod_q;
        end
    end

    // held steady through the output state
    assign sm_tdata = acc_q;

endmodule

/* fir_pkg.sv */
// shared widths, register map, tap count, sequencer states and the ap_ctrl word
package fir_pkg;

    localparam int DATA_W    = 32;
    localparam int ADDR_W    = 12;
    localparam int TAP_NUM   = 11;
    localparam int TAP_IDX_W = 4;

    typedef logic [DATA_W-1:0]    data_t;
    typedef logic [TAP_IDX_W-1:0] tap_idx_t;

    ////////////////////////////////////////////////////////////////////////////
    // AXI-Lite register map
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [ADDR_W-1:0] ADDR_AP_CTRL  = 12'h000;
    // tap i sits at ADDR_TAP_BASE + 4*i
    localparam logic [ADDR_W-1:0] ADDR_TAP_BASE = 12'h040;
    // returned for a tap read while a run is active
    localparam data_t             TAP_ALL_ONES  = '1;

    // one filter pass per input sample
    typedef enum logic [2:0] {
        IDLE,
        WAIT_IN,
        MAC,
        DRAIN,
        OUT
    } fir_state_e;

    // ap_ctrl as a bus word or as status fields
    typedef union packed {
        data_t raw;
        struct packed {
            logic [25:0] rsvd_hi;
            logic        sm_valid;
            logic        ss_ready;
            logic        rsvd_3;
            logic        idle;
            logic        done;
            logic        start;
        } fields;
    } ap_ctrl_u;

endpackage

/* fir_tap_counter.sv */
// tap index counter with clear, step and last-index flag
`timescale 1ns/1ps

module fir_tap_counter (
    input  logic              axis_clk,
    input  logic              axis_rst_n,
    input  logic              cnt_clear,
    input  logic              cnt_step,
    output fir_pkg::tap_idx_t tap_idx,
    output logic              cnt_last
);
    import fir_pkg::*;

    assign cnt_last = (tap_idx == tap_idx_t'(TAP_NUM - 1));

    // wraps back to 0 after the final tap
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            tap_idx <= '0;
        end else if (cnt_clear) begin
            tap_idx <= '0;
        end else if (cnt_step) begin
            if (cnt_last) begin
                tap_idx <= '0;
            end else begin
                tap_idx <= tap_idx + tap_idx_t'(1);
            end
        end
    end

endmodule

/* fir_tap_ram.sv */
// coefficient register file, one bus write port, bus and filter read ports
`timescale 1ns/1ps

module fir_tap_ram (
    input  logic                       axis_clk,
    input  logic                       tap_we,
    input  logic [fir_pkg::ADDR_W-1:0] tap_waddr,
    input  fir_pkg::data_t             tap_wdata,
    input  logic [fir_pkg::ADDR_W-1:0] tap_raddr,
    output fir_pkg::data_t             tap_rdata,
    input  fir_pkg::tap_idx_t          tap_idx,
    output fir_pkg::data_t             tap_coef
);
    import fir_pkg::*;

    data_t    coef_mem [TAP_NUM];
    tap_idx_t wr_idx;
    tap_idx_t rd_idx;

    // byte offset from the tap base, in words
    function automatic tap_idx_t byte_to_idx(input logic [ADDR_W-1:0] byte_addr);
        logic [ADDR_W-1:0] offs;
        offs = byte_addr - ADDR_TAP_BASE;
        return offs[TAP_IDX_W+1:2];
    endfunction

    assign wr_idx = byte_to_idx(tap_waddr);
    assign rd_idx = byte_to_idx(tap_raddr);

    always_ff @(posedge axis_clk) begin
        if (tap_we) begin
            coef_mem[wr_idx] <= tap_wdata;
        end
    end

    assign tap_rdata = (rd_idx < TAP_NUM) ? coef_mem[rd_idx] : '0;
    assign tap_coef  = coef_mem[tap_idx];

endmodule

/* fir_top.sv */
// FIR top level, AXI-Lite control and AXI-Stream data path instances
`timescale 1ns/1ps

module fir_top (
    output logic                       awready,
    output logic                       wready,
    input  logic                       awvalid,
    input  logic [fir_pkg::ADDR_W-1:0] awaddr,
    input  logic                       wvalid,
    input  fir_pkg::data_t             wdata,
    output logic                       arready,
    input  logic                       rready,
    input  logic                       arvalid,
    input  logic [fir_pkg::ADDR_W-1:0] araddr,
    output logic                       rvalid,
    output fir_pkg::data_t             rdata,
    input  logic                       ss_tvalid,
    input  fir_pkg::data_t             ss_tdata,
    input  logic                       ss_tlast,
    output logic                       ss_tready,
    input  logic                       sm_tready,
    output logic                       sm_tvalid,
    output fir_pkg::data_t             sm_tdata,
    output logic                       sm_tlast,
    input  logic                       axis_clk,
    input  logic                       axis_rst_n
);
    import fir_pkg::*;

    logic              start;
    logic              run_done;
    logic              tap_we;
    logic [ADDR_W-1:0] tap_waddr;
    data_t             tap_wdata;
    logic [ADDR_W-1:0] tap_raddr;
    data_t             tap_rdata;
    tap_idx_t          tap_idx;
    logic              cnt_last;
    data_t             tap_coef;
    data_t             hist_sample;
    logic              hist_clear;
    logic              hist_push;
    logic              cnt_clear;
    logic              cnt_step;
    logic              mac_clear;
    logic              mac_en;

    ////////////////////////////////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////////////////////////////////

    fir_axil_regs u_regs (
        .axis_clk  (axis_clk),
        .axis_rst_n(axis_rst_n),
        .awvalid   (awvalid),
        .awaddr    (awaddr),
        .wvalid    (wvalid),
        .wdata     (wdata),
        .arvalid   (arvalid),
        .araddr    (araddr),
        .rready    (rready),
        .awready   (awready),
        .wready    (wready),
        .arready   (arready),
        .rvalid    (rvalid),
        .rdata     (rdata),
        .run_done  (run_done),
        .ss_ready  (ss_tready),
        .sm_valid  (sm_tvalid),
        .start     (start),
        .idle      (),
        .tap_we    (tap_we),
        .tap_waddr (tap_waddr),
        .tap_wdata (tap_wdata),
        .tap_raddr (tap_raddr),
        .tap_rdata (tap_rdata)
    );

    fir_ctrl_fsm u_fsm (
        .axis_clk  (axis_clk),
        .axis_rst_n(axis_rst_n),
        .start     (start),
        .ss_tvalid (ss_tvalid),
        .ss_tlast  (ss_tlast),
        .sm_tready (sm_tready),
        .cnt_last  (cnt_last),
        .ss_tready (ss_tready),
        .sm_tvalid (sm_tvalid),
        .sm_tlast  (sm_tlast),
        .hist_clear(hist_clear),
        .hist_push (hist_push),
        .cnt_clear (cnt_clear),
        .cnt_step  (cnt_step),
        .mac_clear (mac_clear),
        .mac_en    (mac_en),
        .run_done  (run_done)
    );

    ////////////////////////////////////////////////////////////////////////////
    // data path
    ////////////////////////////////////////////////////////////////////////////

    fir_tap_counter u_cnt (
        .axis_clk  (axis_clk),
        .axis_rst_n(axis_rst_n),
        .cnt_clear (cnt_clear),
        .cnt_step  (cnt_step),
        .tap_idx   (tap_idx),
        .cnt_last  (cnt_last)
    );

    fir_tap_ram u_tap_ram (
        .axis_clk (axis_clk),
        .tap_we   (tap_we),
        .tap_waddr(tap_waddr),
        .tap_wdata(tap_wdata),
        .tap_raddr(tap_raddr),
        .tap_rdata(tap_rdata),
        .tap_idx  (tap_idx),
        .tap_coef (tap_coef)
    );

    fir_data_ram u_data_ram (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .hist_clear (hist_clear),
        .hist_push  (hist_push),
        .ss_tdata   (ss_tdata),
        .tap_idx    (tap_idx),
        .hist_sample(hist_sample)
    );

    fir_mac u_mac (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .mac_clear  (mac_clear),
        .mac_en     (mac_en),
        .tap_coef   (tap_coef),
        .hist_sample(hist_sample),
        .sm_tdata   (sm_tdata)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
# build the FIR testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fir -f sources.f -o sim_fir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_fir)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "All checks passed"; then
    exit 0
fi
exit 1

/* sources.f */
fir_pkg.sv
fir_tap_counter.sv
fir_tap_ram.sv
fir_data_ram.sv
fir_mac.sv
fir_ctrl_fsm.sv
fir_axil_regs.sv
fir_top.sv
tb_fir.sv

/* tb_fir.sv */
// FIR testbench with clock, reset, bus and stream tasks, reference model and checks
`timescale 1ns/1ps

module tb_fir;

    localparam int          TAPS        = 11;
    localparam int          NUM_SAMPLES = 20;
    localparam logic [11:0] ADDR_CTRL   = 12'h000;
    // 2 runs of ~40 cycles per sample plus bus traffic, with margin
    localparam int          TIMEOUT_CYCLES = 4000;

    logic        axis_clk;
    logic        axis_rst_n;
    logic        awvalid;
    logic [11:0] awaddr;
    logic        wvalid;
    logic [31:0] wdata;
    logic        awready;
    logic        wready;
    logic        arvalid;
    logic [11:0] araddr;
    logic        arready;
    logic        rready;
    logic        rvalid;
    logic [31:0] rdata;
    logic        ss_tvalid;
    logic [31:0] ss_tdata;
    logic        ss_tlast;
    logic        ss_tready;
    logic        sm_tready;
    logic        sm_tvalid;
    logic [31:0] sm_tdata;
    logic        sm_tlast;

    integer      seed;
    int          cycle_cnt = 0;
    int          run_id;
    logic [31:0] taps    [TAPS];
    logic [31:0] samples [NUM_SAMPLES];
    int          gaps    [NUM_SAMPLES];
    int          stalls  [NUM_SAMPLES];

    fir_top u_fir_top (
        .awready   (awready),
        .wready    (wready),
        .awvalid   (awvalid),
        .awaddr    (awaddr),
        .wvalid    (wvalid),
        .wdata     (wdata),
        .arready   (arready),
        .rready    (rready),
        .arvalid   (arvalid),
        .araddr    (araddr),
        .rvalid    (rvalid),
        .rdata     (rdata),
        .ss_tvalid (ss_tvalid),
        .ss_tdata  (ss_tdata),
        .ss_tlast  (ss_tlast),
        .ss_tready (ss_tready),
        .sm_tready (sm_tready),
        .sm_tvalid (sm_tvalid),
        .sm_tdata  (sm_tdata),
        .sm_tlast  (sm_tlast),
        .axis_clk  (axis_clk),
        .axis_rst_n(axis_rst_n)
    );

    initial begin
        axis_clk = 1'b0;
        forever #2 axis_clk = ~axis_clk;
    end

    always @(posedge axis_clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the DUT stopped answering after %0d cycles", cycle_cnt);
            $display("Checks failed");
            $fatal(1, "simulation timed out");
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks and helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        assert (act === exp) else begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            $display("Checks failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        assert (act === exp) else begin
            $display("FAILED %s: expected %b, actual %b", name, exp, act);
            $display("Checks failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    // inputs change 1 ns after the rising edge
    task automatic step_cycle();
        @(posedge axis_clk);
        #1;
    endtask

    function automatic logic [11:0] tap_addr(input int idx);
        return 12'h040 + 12'(4 * idx);
    endfunction

    // sum of tap i times the sample i places back, zero before the start
    function automatic logic [31:0] fir_model(input int n);
        logic [31:0] acc;
        logic [31:0] x;
        acc = 32'h0;
        for (int i = 0; i < TAPS; i++) begin
            x = (n - i >= 0) ? samples[n - i] : 32'h0;
            acc = acc + taps[i] * x;
        end
        return acc;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // AXI-Lite tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic write_reg(input logic [11:0] addr, input logic [31:0] data);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        step_cycle();
        while (!awready) begin
            step_cycle();
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
    endtask

    task automatic read_reg(input logic [11:0] addr, output logic [31:0] data);
        araddr  = addr;
        arvalid = 1'b1;
        step_cycle();
        while (!arready) begin
            step_cycle();
        end
        arvalid = 1'b0;
        while (!rvalid) begin
            step_cycle();
        end
        data   = rdata;
        rready = 1'b1;
        step_cycle();
        rready = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stream tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic feed_samples();
        for (int i = 0; i < NUM_SAMPLES; i++) begin
            ss_tvalid = 1'b0;
            while (!ss_tready) begin
                step_cycle();
            end
            // valid held back while the DUT is already ready
            repeat (gaps[i]) step_cycle();
            ss_tvalid = 1'b1;
            ss_tdata  = samples[i];
            ss_tlast  = (i == NUM_SAMPLES - 1);
            step_cycle();
        end
        ss_tvalid = 1'b0;
        ss_tlast  = 1'b0;
    endtask

    task automatic collect_outputs();
        logic [31:0] exp;
        logic [31:0] rd;
        for (int j = 0; j < NUM_SAMPLES; j++) begin
            sm_tready = 1'b0;
            while (!sm_tvalid) begin
                step_cycle();
            end
            // output held by back-pressure shows up as sm_valid
            if (j == NUM_SAMPLES - 1) begin
                read_reg(ADDR_CTRL, rd);
                check_word($sformatf("run %0d ap_ctrl output held", run_id),
                           32'h0000_0020, rd);
            end
            repeat (stalls[j]) step_cycle();
            sm_tready = 1'b1;
            exp = fir_model(j);
            check_word($sformatf("run %0d output %0d data", run_id, j), exp, sm_tdata);
            check_flag($sformatf("run %0d output %0d tlast", run_id, j),
                       j == NUM_SAMPLES - 1, sm_tlast);
            step_cycle();
        end
        sm_tready = 1'b0;
    endtask

    // bus traffic while the filter is busy
    task automatic busy_checks(input bit enable);
        logic [31:0] rd;
        if (enable) begin
            repeat (6) step_cycle();
            read_reg(ADDR_CTRL, rd);
            check_flag("busy ap_ctrl idle", 1'b0, rd[2]);
            check_flag("busy ap_ctrl done", 1'b0, rd[1]);
            read_reg(tap_addr(3), rd);
            check_word("busy tap read", 32'hffff_ffff, rd);
            write_reg(tap_addr(2), ~taps[2]);
            write_reg(ADDR_CTRL, 32'h1);
        end
    endtask

    task automatic run_stream(input int id, input bit with_bus);
        logic [31:0] rd;
        for (int i = 0; i < NUM_SAMPLES; i++) begin
            samples[i] = $random(seed);
            gaps[i]    = $unsigned($random(seed)) % 4;
            stalls[i]  = $unsigned($random(seed)) % 4;
        end
        run_id = id;
        write_reg(ADDR_CTRL, 32'h1);
        while (!ss_tready) begin
            step_cycle();
        end
        // waiting for the first sample
        read_reg(ADDR_CTRL, rd);
        check_word($sformatf("run %0d ap_ctrl awaiting input", id), 32'h0000_0010, rd);
        fork
            feed_samples();
            collect_outputs();
            busy_checks(with_bus);
        join
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] rd;
        seed       = 54050;
        axis_rst_n = 1'b0;
        awvalid    = 1'b0;
        awaddr     = '0;
        wvalid     = 1'b0;
        wdata      = '0;
        arvalid    = 1'b0;
        araddr     = '0;
        rready     = 1'b0;
        ss_tvalid  = 1'b0;
        ss_tdata   = '0;
        ss_tlast   = 1'b0;
        sm_tready  = 1'b0;
        repeat (4) @(posedge axis_clk);
        #1;
        axis_rst_n = 1'b1;
        step_cycle();

        // handshake outputs quiet after reset
        check_flag("reset awready", 1'b0, awready);
        check_flag("reset wready", 1'b0, wready);
        check_flag("reset arready", 1'b0, arready);
        check_flag("reset rvalid", 1'b0, rvalid);
        check_flag("reset ss_tready", 1'b0, ss_tready);
        check_flag("reset sm_tvalid", 1'b0, sm_tvalid);
        // idle only
        read_reg(ADDR_CTRL, rd);
        check_word("reset ap_ctrl", 32'h0000_0004, rd);

        for (int i = 0; i < TAPS; i++) begin
            taps[i] = $random(seed);
            write_reg(tap_addr(i), taps[i]);
        end
        for (int i = 0; i < TAPS; i++) begin
            read_reg(tap_addr(i), rd);
            check_word($sformatf("tap %0d readback", i), taps[i], rd);
        end

        run_stream(1, 1'b1);
        check_flag("run 1 no extra output", 1'b0, sm_tvalid);
        // done and idle, then done cleared by the read
        read_reg(ADDR_CTRL, rd);
        check_word("run 1 ap_ctrl first read", 32'h0000_0006, rd);
        read_reg(ADDR_CTRL, rd);
        check_word("run 1 ap_ctrl second read", 32'h0000_0004, rd);
        read_reg(tap_addr(2), rd);
        check_word("tap 2 after busy write", taps[2], rd);

        run_stream(2, 1'b0);
        check_flag("run 2 no extra output", 1'b0, sm_tvalid);
        read_reg(ADDR_CTRL, rd);
        check_word("run 2 ap_ctrl", 32'h0000_0006, rd);

        $display("All checks passed");
        $finish;
    end

endmodule
